// File: rtl/mshr_geom_pkg.sv
package mshr_geom_pkg;

    localparam int ADDR_W   = 15;               // Byte address
    localparam int LINE_LSB = 4;                // 16-byte lines
    localparam int LINE_W   = ADDR_W - LINE_LSB;

    // One bit per load/store queue slot
    localparam int QSLOTS = 8;

    localparam int N_ENTRIES_DEF = 12;

    typedef logic [LINE_W-1:0] line_addr_t;
    typedef logic [QSLOTS-1:0] slot_mask_t;

endpackage

// File: rtl/mshr_op_pkg.sv
package mshr_op_pkg;

    // Picks the mask a waiting slot joins
    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } req_op_e;

    // Registered wake-up result
    typedef struct packed {
        logic                      valid;
        mshr_geom_pkg::slot_mask_t rd_slots;
        mshr_geom_pkg::slot_mask_t sw_slots;
    } wake_t;

endpackage

// File: rtl/mshr_ctrl.sv
module mshr_ctrl (
    input  logic                                     clk,
    input  logic                                     arst_n,

    input  logic                                     req_valid,
    input  mshr_op_pkg::req_op_e                     req_op,
    input  mshr_geom_pkg::line_addr_t                req_line,
    input  logic [$clog2(mshr_geom_pkg::QSLOTS)-1:0] req_slot,

    input  logic                                     fill_valid,
    input  mshr_geom_pkg::line_addr_t                fill_line,

    input  logic                                     hit_any,
    input  logic                                     fill_any,
    input  logic                                     free_any,

    output logic                                     do_alloc,
    output logic                                     do_merge,
    output logic                                     do_free,
    output logic                                     bypass,
    output logic                                     req_stall,
    output mshr_geom_pkg::slot_mask_t                req_rd_mask,
    output mshr_geom_pkg::slot_mask_t                req_sw_mask
);

    mshr_geom_pkg::slot_mask_t slot_onehot;
    logic                      same_line;
    logic                      fill_dup;

    logic                      freed_q;      // An entry was freed last cycle
    mshr_geom_pkg::line_addr_t freed_line_q;

    assign slot_onehot = mshr_geom_pkg::slot_mask_t'(1) << req_slot;

    always_comb begin
        req_rd_mask = '0;
        req_sw_mask = '0;
        case (req_op)
            mshr_op_pkg::OP_LOAD:  req_rd_mask = slot_onehot;
            mshr_op_pkg::OP_STORE: req_sw_mask = slot_onehot;
            default: ;
        endcase
    end

    // Repeat of the fill that just retired its entry
    assign fill_dup = freed_q && (fill_line == freed_line_q);

    assign do_free   = fill_valid && fill_any && !fill_dup;
    assign same_line = (req_line == fill_line);

    // Same-line fill wins, request rides along on the wake pulse
    assign bypass    = req_valid && do_free && same_line;

    assign do_merge  = req_valid && hit_any && !bypass;
    assign do_alloc  = req_valid && !hit_any && free_any && !bypass;
    assign req_stall = req_valid && !hit_any && !free_any && !bypass;  // Dropped, retry

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            freed_q <= 1'b0;
        end else begin
            freed_q <= do_free;
        end
    end

    always_ff @(posedge clk) begin
        if (do_free) begin
            freed_line_q <= fill_line;
        end
    end

endmodule

// File: rtl/mshr_addr_match.sv
module mshr_addr_match #(
    parameter int N_ENTRIES = mshr_geom_pkg::N_ENTRIES_DEF,
    localparam int IDX_W    = $clog2(N_ENTRIES)
) (
    input  logic [N_ENTRIES-1:0]                            entry_valid,
    input  mshr_geom_pkg::line_addr_t [N_ENTRIES-1:0]       entry_line,
    input  mshr_geom_pkg::line_addr_t                       req_line,
    input  mshr_geom_pkg::line_addr_t                       fill_line,

    output logic                                            hit_any,
    output logic [IDX_W-1:0]                                hit_idx,
    output logic                                            fill_any,
    output logic [IDX_W-1:0]                                fill_idx,
    output logic                                            free_any,
    output logic [IDX_W-1:0]                                free_idx
);

    logic [N_ENTRIES-1:0] hit_vec;
    logic [N_ENTRIES-1:0] fill_vec;
    logic [N_ENTRIES-1:0] free_vec;

    // Lowest set bit wins
    function automatic logic [IDX_W-1:0] first_set(input logic [N_ENTRIES-1:0] vec);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = N_ENTRIES - 1; i >= 0; i--) begin
            if (vec[i]) idx = IDX_W'(i);
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < N_ENTRIES; i++) begin
            hit_vec[i]  = entry_valid[i] && (entry_line[i] == req_line);
            fill_vec[i] = entry_valid[i] && (entry_line[i] == fill_line);
        end
    end

    assign free_vec = ~entry_valid;

    assign hit_any  = |hit_vec;     // At most one, merge keeps lines unique
    assign fill_any = |fill_vec;
    assign free_any = |free_vec;

    assign hit_idx  = first_set(hit_vec);
    assign fill_idx = first_set(fill_vec);
    assign free_idx = first_set(free_vec);

endmodule

// File: rtl/mshr_entry_file.sv
module mshr_entry_file #(
    parameter int N_ENTRIES = mshr_geom_pkg::N_ENTRIES_DEF,
    localparam int IDX_W    = $clog2(N_ENTRIES)
) (
    input  logic                                      clk,
    input  logic                                      arst_n,

    input  logic                                      do_alloc,
    input  logic                                      do_merge,
    input  logic                                      do_free,
    input  logic                                      bypass,

    input  logic [IDX_W-1:0]                          hit_idx,
    input  logic [IDX_W-1:0]                          fill_idx,
    input  logic [IDX_W-1:0]                          free_idx,

    input  mshr_geom_pkg::line_addr_t                 req_line,
    input  mshr_geom_pkg::slot_mask_t                 req_rd_mask,
    input  mshr_geom_pkg::slot_mask_t                 req_sw_mask,

    output logic [N_ENTRIES-1:0]                      entry_valid,
    output mshr_geom_pkg::line_addr_t [N_ENTRIES-1:0] entry_line,

    output logic                                      wake_valid,
    output mshr_geom_pkg::slot_mask_t                 wake_rd_slots,
    output mshr_geom_pkg::slot_mask_t                 wake_sw_slots
);

    logic [N_ENTRIES-1:0]                      valid_q;
    mshr_geom_pkg::line_addr_t [N_ENTRIES-1:0] line_q;
    mshr_geom_pkg::slot_mask_t [N_ENTRIES-1:0] rd_q;     // Waiting loads
    mshr_geom_pkg::slot_mask_t [N_ENTRIES-1:0] sw_q;     // Waiting stores

    mshr_geom_pkg::slot_mask_t                 free_rd;
    mshr_geom_pkg::slot_mask_t                 free_sw;
    mshr_op_pkg::wake_t                        wake_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            if (do_alloc) begin
                valid_q[free_idx] <= 1'b1;
            end
            if (do_free) begin
                valid_q[fill_idx] <= 1'b0;
            end
        end
    end

    // Allocate and merge never hit the same entry in one cycle
    always_ff @(posedge clk) begin
        if (do_alloc) begin
            line_q[free_idx] <= req_line;
            rd_q[free_idx]   <= req_rd_mask;
            sw_q[free_idx]   <= req_sw_mask;
        end
        if (do_merge) begin
            rd_q[hit_idx] <= rd_q[hit_idx] | req_rd_mask;
            sw_q[hit_idx] <= sw_q[hit_idx] | req_sw_mask;
        end
    end

    // Freed entry plus a same-cycle request to that line
    assign free_rd = rd_q[fill_idx] | (bypass ? req_rd_mask : '0);
    assign free_sw = sw_q[fill_idx] | (bypass ? req_sw_mask : '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wake_q <= '0;
        end else begin
            wake_q.valid    <= do_free;
            wake_q.rd_slots <= do_free ? free_rd : '0;
            wake_q.sw_slots <= do_free ? free_sw : '0;
        end
    end

    assign entry_valid   = valid_q;
    assign entry_line    = line_q;

    assign wake_valid    = wake_q.valid;
    assign wake_rd_slots = wake_q.rd_slots;
    assign wake_sw_slots = wake_q.sw_slots;

endmodule

// File: rtl/mshr_top.sv
module mshr_top #(
    parameter int N_ENTRIES = mshr_geom_pkg::N_ENTRIES_DEF
) (
    input  logic                                     clk,
    input  logic                                     arst_n,

    input  logic                                     req_valid,
    input  mshr_op_pkg::req_op_e                     req_op,
    input  logic [mshr_geom_pkg::ADDR_W-1:0]         req_addr,
    input  logic [$clog2(mshr_geom_pkg::QSLOTS)-1:0] req_slot,

    input  logic                                     fill_valid,
    input  logic [mshr_geom_pkg::ADDR_W-1:0]         fill_addr,

    output logic                                     mshr_hit,
    output logic                                     mshr_full,
    output logic                                     req_stall,

    output logic                                     wake_valid,
    output mshr_geom_pkg::slot_mask_t                wake_rd_slots,
    output mshr_geom_pkg::slot_mask_t                wake_sw_slots
);

    localparam int IDX_W = $clog2(N_ENTRIES);

    mshr_geom_pkg::line_addr_t                 req_line;
    mshr_geom_pkg::line_addr_t                 fill_line;

    logic [N_ENTRIES-1:0]                      entry_valid;
    mshr_geom_pkg::line_addr_t [N_ENTRIES-1:0] entry_line;

    logic                                      hit_any;
    logic                                      fill_any;
    logic                                      free_any;
    logic [IDX_W-1:0]                          hit_idx;
    logic [IDX_W-1:0]                          fill_idx;
    logic [IDX_W-1:0]                          free_idx;

    logic                                      do_alloc;
    logic                                      do_merge;
    logic                                      do_free;
    logic                                      bypass;
    mshr_geom_pkg::slot_mask_t                 req_rd_mask;
    mshr_geom_pkg::slot_mask_t                 req_sw_mask;

    assign req_line  = req_addr[mshr_geom_pkg::ADDR_W-1:mshr_geom_pkg::LINE_LSB];
    assign fill_line = fill_addr[mshr_geom_pkg::ADDR_W-1:mshr_geom_pkg::LINE_LSB];

    assign mshr_hit  = hit_any;
    assign mshr_full = !free_any;

    mshr_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_line   (req_line),
        .req_slot   (req_slot),
        .fill_valid (fill_valid),
        .fill_line  (fill_line),
        .hit_any    (hit_any),
        .fill_any   (fill_any),
        .free_any   (free_any),
        .do_alloc   (do_alloc),
        .do_merge   (do_merge),
        .do_free    (do_free),
        .bypass     (bypass),
        .req_stall  (req_stall),
        .req_rd_mask(req_rd_mask),
        .req_sw_mask(req_sw_mask)
    );

    mshr_addr_match #(.N_ENTRIES(N_ENTRIES)) u_match (
        .entry_valid(entry_valid),
        .entry_line (entry_line),
        .req_line   (req_line),
        .fill_line  (fill_line),
        .hit_any    (hit_any),
        .hit_idx    (hit_idx),
        .fill_any   (fill_any),
        .fill_idx   (fill_idx),
        .free_any   (free_any),
        .free_idx   (free_idx)
    );

    mshr_entry_file #(.N_ENTRIES(N_ENTRIES)) u_entries (
        .clk          (clk),
        .arst_n       (arst_n),
        .do_alloc     (do_alloc),
        .do_merge     (do_merge),
        .do_free      (do_free),
        .bypass       (bypass),
        .hit_idx      (hit_idx),
        .fill_idx     (fill_idx),
        .free_idx     (free_idx),
        .req_line     (req_line),
        .req_rd_mask  (req_rd_mask),
        .req_sw_mask  (req_sw_mask),
        .entry_valid  (entry_valid),
        .entry_line   (entry_line),
        .wake_valid   (wake_valid),
        .wake_rd_slots(wake_rd_slots),
        .wake_sw_slots(wake_sw_slots)
    );

endmodule

// File: sim/mshr_properties.sv
module mshr_properties (
    input logic clk,
    input logic arst_n,
    input logic fill_valid,
    input logic req_stall,
    input logic mshr_full,
    input logic mshr_hit,
    input logic wake_valid
);

    a_wake_after_reset: assert property (@(posedge clk) !$past(arst_n) |-> !wake_valid)
        else $error("wake_valid high in the cycle after reset");

    // A stalled request is a miss with every entry in use
    a_stall_full: assert property (@(posedge clk) disable iff (!arst_n)
        req_stall |-> mshr_full && !mshr_hit)
        else $error("req_stall without mshr_full, or together with mshr_hit");

    a_wake_follows_fill: assert property (@(posedge clk) disable iff (!arst_n)
        wake_valid |-> $past(fill_valid))
        else $error("wake_valid without a fill in the cycle before");

endmodule

bind mshr_top mshr_properties props_i (
    .clk(clk), .arst_n(arst_n), .fill_valid(fill_valid), .req_stall(req_stall),
    .mshr_full(mshr_full), .mshr_hit(mshr_hit), .wake_valid(wake_valid)
);

// File: sim/mshr_tb.sv
module mshr_tb;

    localparam int N      = mshr_geom_pkg::N_ENTRIES_DEF;
    localparam int ADDR_W = mshr_geom_pkg::ADDR_W;
    localparam int LSB    = mshr_geom_pkg::LINE_LSB;

    logic                      clk = 1'b0;
    logic                      arst_n;
    logic                      req_valid;
    mshr_op_pkg::req_op_e      req_op;
    logic [ADDR_W-1:0]         req_addr;
    logic [2:0]                req_slot;
    logic                      fill_valid;
    logic [ADDR_W-1:0]         fill_addr;
    logic                      mshr_hit;
    logic                      mshr_full;
    logic                      req_stall;
    logic                      wake_valid;
    mshr_geom_pkg::slot_mask_t wake_rd_slots;
    mshr_geom_pkg::slot_mask_t wake_sw_slots;

    string                     test_name = "reset";
    logic [15:0]               lfsr = 16'd21;
    logic                      seen_hit;
    logic                      seen_full;
    logic                      seen_stall;

    // Reference copy of the entry array and the wake register
    logic [N-1:0]              m_valid;
    mshr_geom_pkg::line_addr_t m_line [N];
    mshr_geom_pkg::slot_mask_t m_rd [N];
    mshr_geom_pkg::slot_mask_t m_sw [N];
    logic                      m_wv;
    mshr_geom_pkg::slot_mask_t m_wrd;
    mshr_geom_pkg::slot_mask_t m_wsw;

    mshr_top #(.N_ENTRIES(N)) dut_i (.*);

    always #5 clk = ~clk;

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [ADDR_W-1:0] line_addr(input int line);
        return ADDR_W'(line << LSB);
    endfunction

    function automatic void model_reset();
        m_valid = '0;
        m_wv    = 1'b0;
        m_wrd   = '0;
        m_wsw   = '0;
    endfunction

    // Expected flags for this cycle, then the state after the edge
    function automatic void ref_step(input logic rv, input mshr_op_pkg::req_op_e op,
                                     input logic [ADDR_W-1:0] raddr, input logic [2:0] slot,
                                     input logic fv, input logic [ADDR_W-1:0] faddr,
                                     output logic hit, output logic full, output logic stall);
        mshr_geom_pkg::line_addr_t rl;
        mshr_geom_pkg::line_addr_t fl;
        mshr_geom_pkg::slot_mask_t bit_rd;
        mshr_geom_pkg::slot_mask_t bit_sw;
        int                        h;
        int                        f;
        int                        fr;
        logic                      byp;
        rl     = raddr[ADDR_W-1:LSB];
        fl     = faddr[ADDR_W-1:LSB];
        bit_rd = '0;
        bit_sw = '0;
        if (op == mshr_op_pkg::OP_LOAD) bit_rd[slot] = 1'b1;
        else bit_sw[slot] = 1'b1;
        h  = -1;
        f  = -1;
        fr = -1;
        for (int i = N - 1; i >= 0; i--) begin
            if (m_valid[i] && m_line[i] == rl) h = i;
            if (m_valid[i] && m_line[i] == fl) f = i;
            if (!m_valid[i]) fr = i;                 // Lowest free entry
        end
        hit   = (h >= 0);
        full  = (fr < 0);
        byp   = rv && fv && (f >= 0) && (rl == fl);
        stall = rv && !hit && full && !byp;
        m_wv  = fv && (f >= 0);
        m_wrd = '0;
        m_wsw = '0;
        if (m_wv) begin
            m_wrd      = m_rd[f] | (byp ? bit_rd : '0);
            m_wsw      = m_sw[f] | (byp ? bit_sw : '0);
            m_valid[f] = 1'b0;
        end
        if (rv && !byp && hit) begin
            m_rd[h] = m_rd[h] | bit_rd;
            m_sw[h] = m_sw[h] | bit_sw;
        end else if (rv && !byp && !full) begin
            m_valid[fr] = 1'b1;
            m_line[fr]  = rl;
            m_rd[fr]    = bit_rd;
            m_sw[fr]    = bit_sw;
        end
    endfunction

    task automatic report_failure();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_mask(input string name, input mshr_geom_pkg::slot_mask_t exp,
                              input mshr_geom_pkg::slot_mask_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            report_failure();
        end
    endtask

    // One cycle of stimulus, flags sampled at the edge that acts on it
    task automatic apply(input logic rv, input mshr_op_pkg::req_op_e op,
                         input logic [ADDR_W-1:0] raddr, input logic [2:0] slot,
                         input logic fv, input logic [ADDR_W-1:0] faddr);
        req_valid  = rv;
        req_op     = op;
        req_addr   = raddr;
        req_slot   = slot;
        fill_valid = fv;
        fill_addr  = faddr;
        @(posedge clk);
        seen_hit   = mshr_hit;
        seen_full  = mshr_full;
        seen_stall = req_stall;
        @(negedge clk);
        req_valid  = 1'b0;
        fill_valid = 1'b0;
    endtask

    task automatic wait_wake(input mshr_geom_pkg::slot_mask_t exp_rd,
                             input mshr_geom_pkg::slot_mask_t exp_sw);
        int waited;
        waited = 0;
        while (!wake_valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!wake_valid) begin
            $display("Timeout: no wake-up pulse arrived in test %s", test_name);
            report_failure();
        end
        check_mask({test_name, " wake_rd_slots"}, exp_rd, wake_rd_slots);
        check_mask({test_name, " wake_sw_slots"}, exp_sw, wake_sw_slots);
    endtask

    always @(posedge clk) begin
        logic e_hit;
        logic e_full;
        logic e_stall;
        if (!arst_n) begin
            model_reset();
        end else begin
            check_flag({test_name, " wake_valid"}, m_wv, wake_valid);
            check_mask({test_name, " wake_rd_slots"}, m_wrd, wake_rd_slots);
            check_mask({test_name, " wake_sw_slots"}, m_wsw, wake_sw_slots);
            ref_step(req_valid, req_op, req_addr, req_slot, fill_valid, fill_addr,
                     e_hit, e_full, e_stall);
            check_flag({test_name, " mshr_hit"}, e_hit, mshr_hit);
            check_flag({test_name, " mshr_full"}, e_full, mshr_full);
            check_flag({test_name, " req_stall"}, e_stall, req_stall);
        end
    end

    initial begin
        logic [15:0] r;
        logic [15:0] s;
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        req_op     = mshr_op_pkg::OP_LOAD;
        req_addr   = '0;
        req_slot   = '0;
        fill_valid = 1'b0;
        fill_addr  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_name = "load_miss_fill";
        apply(1'b1, mshr_op_pkg::OP_LOAD, line_addr(5) | 15'h8, 3'd3, 1'b0, '0);
        apply(1'b0, mshr_op_pkg::OP_LOAD, line_addr(5), 3'd0, 1'b0, '0);
        check_flag("load_miss_fill mshr_hit", 1'b1, seen_hit);
        apply(1'b0, mshr_op_pkg::OP_LOAD, '0, 3'd0, 1'b1, line_addr(5));
        wait_wake(8'h08, 8'h00);

        test_name = "merge";
        apply(1'b1, mshr_op_pkg::OP_LOAD, line_addr(6), 3'd1, 1'b0, '0);
        apply(1'b1, mshr_op_pkg::OP_STORE, line_addr(6) | 15'h4, 3'd5, 1'b0, '0);
        apply(1'b1, mshr_op_pkg::OP_LOAD, line_addr(6), 3'd2, 1'b0, '0);
        apply(1'b0, mshr_op_pkg::OP_LOAD, '0, 3'd0, 1'b1, line_addr(6));
        wait_wake(8'h06, 8'h20);

        test_name = "full_stall";
        for (int i = 0; i < N; i++) begin
            apply(1'b1, mshr_op_pkg::OP_LOAD, line_addr(16 + i), 3'(i % 8), 1'b0, '0);
        end
        apply(1'b1, mshr_op_pkg::OP_STORE, line_addr(100), 3'd7, 1'b0, '0);
        check_flag("full_stall mshr_full", 1'b1, seen_full);
        check_flag("full_stall req_stall", 1'b1, seen_stall);

        test_name = "fill_absent";
        apply(1'b0, mshr_op_pkg::OP_LOAD, '0, 3'd0, 1'b1, line_addr(100));
        check_flag("fill_absent wake_valid", 1'b0, wake_valid);

        test_name = "full_merge";
        apply(1'b1, mshr_op_pkg::OP_STORE, line_addr(16), 3'd6, 1'b0, '0);
        check_flag("full_merge mshr_hit", 1'b1, seen_hit);
        check_flag("full_merge req_stall", 1'b0, seen_stall);
        for (int i = 0; i < N; i++) begin
            apply(1'b0, mshr_op_pkg::OP_LOAD, '0, 3'd0, 1'b1, line_addr(16 + i));
            wait_wake(8'h01 << (i % 8), (i == 0) ? 8'h40 : 8'h00);
        end

        test_name = "bypass";
        apply(1'b1, mshr_op_pkg::OP_LOAD, line_addr(50), 3'd0, 1'b0, '0);
        apply(1'b1, mshr_op_pkg::OP_STORE, line_addr(50), 3'd4, 1'b1, line_addr(50));
        check_flag("bypass req_stall", 1'b0, seen_stall);
        wait_wake(8'h01, 8'h10);
        apply(1'b0, mshr_op_pkg::OP_LOAD, line_addr(50), 3'd0, 1'b0, '0);
        check_flag("bypass mshr_hit", 1'b0, seen_hit);

        test_name = "random_mix";
        for (int n = 0; n < 3000; n++) begin
            r = rand_bits(11);
            s = rand_bits(8);
            apply(r[0], mshr_op_pkg::req_op_e'(r[1]), {7'd0, r[5:2], s[7:4]}, r[8:6],
                  r[10:9] == 2'b00, {7'd0, s[3:0], 4'd0});
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: sim.f
rtl/mshr_geom_pkg.sv
rtl/mshr_op_pkg.sv
rtl/mshr_ctrl.sv
rtl/mshr_addr_match.sv
rtl/mshr_entry_file.sv
rtl/mshr_top.sv
sim/mshr_properties.sv
sim/mshr_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -j 0 --top-module mshr_tb -Mdir obj_dir -f sim.f
	./obj_dir/Vmshr_tb

clean:
	rm -rf obj_dir
